// File: cl_hello_world.sv
//------------------------------------------------------------
// Hello world custom logic top
// OCL AXI-Lite slave with a byte-swapping hello register and
// a virtual LED register masked by the DIP switches
//------------------------------------------------------------
`timescale 1ns/1ps

module cl_hello_world
  import hello_pkg::*;
#(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  // OCL write address
  input  logic                  awvalid,
  input  logic [ADDR_WIDTH-1:0] awaddr,
  output logic                  awready,
  // OCL write data
  input  logic                  wvalid,
  input  logic [data_width-1:0] wdata,
  output logic                  wready,
  // OCL write response
  output logic                  bvalid,
  input  logic                  bready,
  // OCL read address
  input  logic                  arvalid,
  input  logic [ADDR_WIDTH-1:0] araddr,
  output logic                  arready,
  // OCL read data
  output logic                  rvalid,
  output logic [data_width-1:0] rdata,
  input  logic                  rready,
  // Virtual DIP switches and LEDs
  input  logic [led_width-1:0]  vdip,
  output logic [led_width-1:0]  led
);

  //------------------------------------------------------------
  // Internal links
  //------------------------------------------------------------
  // Write channel to registers
  logic                  reg_wr_en;
  logic [ADDR_WIDTH-1:0] reg_wr_addr;
  logic [data_width-1:0] reg_wr_data;
  // Registers to read channel
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [data_width-1:0] rd_data;

  // Write side
  ocl_write_channel #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_write_channel (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bready          (bready),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data)
  );

  // Register file
  hello_regs #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .vdip            (vdip),
    .led             (led)
  );

  // Read side
  ocl_read_channel #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_read_channel (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rready          (rready),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

endmodule

// File: hello_pkg.sv
//------------------------------------------------------------
// Hello world register block definitions
// Bus widths, register map, fallback read word and the
// two views of the hello register
//------------------------------------------------------------
package hello_pkg;

  //------------------------------------------------------------
  // Widths
  //------------------------------------------------------------
  // AXI-Lite data path, four bytes wide for the byte swap
  parameter int data_width = 32;

  // Virtual LEDs and virtual DIP switches
  parameter int led_width = 16;

  //------------------------------------------------------------
  // Register map
  //------------------------------------------------------------
  // Offsets are kept at 32 bits and cut down to the bus address width
  // where they are compared
  parameter logic [31:0] hello_reg_addr = 32'h0000_0000;
  parameter logic [31:0] vled_reg_addr  = 32'h0000_0004;

  // Returned for any offset outside the map
  parameter logic [data_width-1:0] unimpl_reg_value = 32'hdead_dead;

  //------------------------------------------------------------
  // Hello register word
  //------------------------------------------------------------
  // Written as one word, read back per byte for the swap
  typedef union packed {
    logic [data_width-1:0]         word;
    logic [data_width/8-1:0][7:0] bytes;
  } hello_word_t;

endpackage

// File: hello_regs.sv
//------------------------------------------------------------
// Hello world and virtual LED registers
// Stores the hello word, shadows its low half onto the LEDs
// and decodes the read address
//------------------------------------------------------------
`timescale 1ns/1ps

module hello_regs
  import hello_pkg::*;
#(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  // Write port from the write channel
  input  logic                  reg_wr_en,
  input  logic [ADDR_WIDTH-1:0] reg_wr_addr,
  input  logic [data_width-1:0] reg_wr_data,
  // Read port from the read channel
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [data_width-1:0] rd_data,
  // Virtual DIP switches and LEDs
  input  logic [led_width-1:0]  vdip,
  output logic [led_width-1:0]  led
);

  hello_word_t          hello_q;
  hello_word_t          hello_swapped;
  logic [led_width-1:0] vled_q;
  logic                 hello_wr;

  //------------------------------------------------------------
  // Hello register, offset 0x00
  //------------------------------------------------------------
  assign hello_wr = reg_wr_en && (reg_wr_addr == ADDR_WIDTH'(hello_reg_addr));

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q.word <= '0;
    end else if (hello_wr) begin
      hello_q.word <= reg_wr_data;
    end
  end

  // Byte order reversed on the way out
  always_comb begin
    for (int i = 0; i < data_width / 8; i++) begin
      hello_swapped.bytes[i] = hello_q.bytes[data_width/8-1-i];
    end
  end

  //------------------------------------------------------------
  // Virtual LED register, offset 0x04
  //------------------------------------------------------------
  // Read-only, trails the hello low half by one cycle
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= '0;
    end else begin
      vled_q <= hello_q.word[led_width-1:0];
    end
  end

  // LEDs only light where the DIP switch is on
  assign led = vled_q & vdip;

  //------------------------------------------------------------
  // Read decode
  //------------------------------------------------------------
  always_comb begin
    if (rd_addr == ADDR_WIDTH'(hello_reg_addr)) begin
      rd_data = hello_swapped.word;
    end else if (rd_addr == ADDR_WIDTH'(vled_reg_addr)) begin
      rd_data = {{(data_width-led_width){1'b0}}, vled_q};
    end else begin
      // Anything unmapped
      rd_data = unimpl_reg_value;
    end
  end

endmodule

// File: ocl_read_channel.sv
//------------------------------------------------------------
// OCL AXI-Lite read channel
// Captures one read address and returns the decoded word
// through a registered response
//------------------------------------------------------------
`timescale 1ns/1ps

module ocl_read_channel
  import hello_pkg::*;
#(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  // Read address
  input  logic                  arvalid,
  input  logic [ADDR_WIDTH-1:0] araddr,
  output logic                  arready,
  // Read data
  output logic                  rvalid,
  output logic [data_width-1:0] rdata,
  input  logic                  rready,
  // Register decode port
  output logic [ADDR_WIDTH-1:0] rd_addr,
  input  logic [data_width-1:0] rd_data
);

  logic                  rd_pending;
  logic [ADDR_WIDTH-1:0] rd_addr_q;
  logic                  ar_hs;

  //------------------------------------------------------------
  // Stage 1, address capture
  //------------------------------------------------------------
  // One read in flight, so a held arvalid is taken only once
  assign arready = ~rd_pending & ~rvalid;
  assign ar_hs   = arvalid & arready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pending <= 1'b0;
    end else begin
      // Pending lasts exactly one cycle
      rd_pending <= ar_hs;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_hs) begin
      rd_addr_q <= araddr;
    end
  end

  // Decode runs off the captured address
  assign rd_addr = rd_addr_q;

  //------------------------------------------------------------
  // Stage 2, registered response
  //------------------------------------------------------------
  // Address edge is the first, rvalid is set on the second
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end else if (rd_pending) begin
      rvalid <= 1'b1;
    end
  end

  // Data loaded once per read, held through back-pressure
  always_ff @(posedge clk_main_a0) begin
    if (rd_pending) begin
      rdata <= rd_data;
    end
  end

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------
  // Response stable while the master stalls
  a_rvalid_hold : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata)
  );

  // Never two reads in flight
  a_single_read : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(rd_pending && rvalid)
  );

endmodule

// File: ocl_write_channel.sv
//------------------------------------------------------------
// OCL AXI-Lite write channel
// Takes one address, then one data beat, answers with a write
// response and hands the data to the register stage
//------------------------------------------------------------
`timescale 1ns/1ps

module ocl_write_channel
  import hello_pkg::*;
#(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  // Write address
  input  logic                  awvalid,
  input  logic [ADDR_WIDTH-1:0] awaddr,
  output logic                  awready,
  // Write data
  input  logic                  wvalid,
  input  logic [data_width-1:0] wdata,
  output logic                  wready,
  // Write response
  output logic                  bvalid,
  input  logic                  bready,
  // Register write port
  output logic                  reg_wr_en,
  output logic [ADDR_WIDTH-1:0] reg_wr_addr,
  output logic [data_width-1:0] reg_wr_data
);

  logic                  wr_active;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic                  aw_hs;
  logic                  b_hs;

  //------------------------------------------------------------
  // Handshakes
  //------------------------------------------------------------
  // New address only when no write is open
  assign awready = ~wr_active;
  assign aw_hs   = awvalid & awready;

  // Data taken in the cycle wvalid shows up
  // Blocked once the response is out, so one beat per address
  assign wready = wr_active & wvalid & ~bvalid;

  // Response accepted by the master, write is done
  assign b_hs = bvalid & bready;

  //------------------------------------------------------------
  // Write state
  //------------------------------------------------------------
  // Open on the address edge, close on the response edge
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
    end else if (b_hs) begin
      wr_active <= 1'b0;
    end else if (aw_hs) begin
      wr_active <= 1'b1;
    end
  end

  // Address held for the data beat
  always_ff @(posedge clk_main_a0) begin
    if (aw_hs) begin
      wr_addr <= awaddr;
    end
  end

  // Response one cycle after the data edge
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (b_hs) begin
      bvalid <= 1'b0;
    end else if (wready) begin
      bvalid <= 1'b1;
    end
  end

  // Register stage sees the beat in the handshake cycle
  assign reg_wr_en   = wready;
  assign reg_wr_addr = wr_addr;
  assign reg_wr_data = wdata;

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------
  // Response held and no new address until the master takes it
  a_bvalid_hold : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid && !awready
  );

endmodule

// File: project.f
hello_pkg.sv
ocl_write_channel.sv
hello_regs.sv
ocl_read_channel.sv
cl_hello_world.sv
tb_cl_hello_world.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the hello world testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_cl_hello_world \
  -f project.f

status=0
sim_out="$(./obj_dir/Vtb_cl_hello_world 2>&1)" || status=$?
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
echo "Pass line not found, simulator exit status $status"
exit 1

// File: tb_cl_hello_world.sv
//------------------------------------------------------------
// Testbench for the hello world register block
// Applies a table of OCL writes and reads with random response
// back-pressure, checks read data, latency and the LEDs
//------------------------------------------------------------
`timescale 1ns/1ps

module tb_cl_hello_world;

  localparam int clk_period = 20;
  localparam int num_rows   = 18;
  // Generous per-row allowance in clock cycles
  localparam int row_cycles = 20;
  localparam int watchdog_ns = (num_rows * row_cycles + 10) * clk_period;

  localparam logic op_wr = 1'b1;
  localparam logic op_rd = 1'b0;

  // Hello register offset as seen from the host
  localparam logic [31:0] hello_addr = 32'h0000_0000;

  typedef struct packed {
    logic        op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [15:0] vdip;
    logic [31:0] exp_rdata;
  } access_t;

  logic        clk_main_a0;
  logic        rst_main_n_sync;
  logic        awvalid;
  logic [31:0] awaddr;
  logic        awready;
  logic        wvalid;
  logic [31:0] wdata;
  logic        wready;
  logic        bvalid;
  logic        bready;
  logic        arvalid;
  logic [31:0] araddr;
  logic        arready;
  logic        rvalid;
  logic [31:0] rdata;
  logic        rready;
  logic [15:0] vdip;
  logic [15:0] led;

  // Last word that reached the hello register
  logic [31:0] last_hello;
  integer      seed = 32'ha896_2db4;

  //------------------------------------------------------------
  // Access table
  //------------------------------------------------------------
  // op, address, write data, vdip, expected read data
  access_t accesses [num_rows] = '{
    // Reset values
    '{op_rd, 32'h0000_0000, 32'h0000_0000, 16'hffff, 32'h0000_0000},
    '{op_rd, 32'h0000_0004, 32'h0000_0000, 16'hffff, 32'h0000_0000},
    // Byte swap and LED shadow
    '{op_wr, 32'h0000_0000, 32'h1234_5678, 16'hffff, 32'h0000_0000},
    '{op_rd, 32'h0000_0000, 32'h0000_0000, 16'hffff, 32'h7856_3412},
    '{op_rd, 32'h0000_0004, 32'h0000_0000, 16'h00ff, 32'h0000_5678},
    '{op_wr, 32'h0000_0000, 32'ha5c3_0ff1, 16'h00ff, 32'h0000_0000},
    '{op_rd, 32'h0000_0000, 32'h0000_0000, 16'h0f0f, 32'hf10f_c3a5},
    '{op_rd, 32'h0000_0004, 32'h0000_0000, 16'h0f0f, 32'h0000_0ff1},
    // Unmapped reads
    '{op_rd, 32'h0000_0008, 32'h0000_0000, 16'hf0f0, 32'hdead_dead},
    '{op_rd, 32'h0000_0100, 32'h0000_0000, 16'hf0f0, 32'hdead_dead},
    // Unmapped write leaves hello alone
    '{op_wr, 32'h0000_000c, 32'h1122_3344, 16'hf0f0, 32'h0000_0000},
    '{op_rd, 32'h0000_0000, 32'h0000_0000, 16'haaaa, 32'hf10f_c3a5},
    // LED register is read-only
    '{op_wr, 32'h0000_0004, 32'hffff_ffff, 16'h5555, 32'h0000_0000},
    '{op_rd, 32'h0000_0004, 32'h0000_0000, 16'h5555, 32'h0000_0ff1},
    '{op_wr, 32'h0000_0000, 32'hcafe_beef, 16'h1234, 32'h0000_0000},
    '{op_rd, 32'h0000_0000, 32'h0000_0000, 16'h1234, 32'hefbe_feca},
    '{op_rd, 32'h0000_0004, 32'h0000_0000, 16'hffff, 32'h0000_beef},
    // Misaligned offset is unmapped too
    '{op_rd, 32'h0000_0002, 32'h0000_0000, 16'h0000, 32'hdead_dead}
  };

  cl_hello_world #(
    .ADDR_WIDTH (32)
  ) u_cl_hello_world (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rready          (rready),
    .vdip            (vdip),
    .led             (led)
  );

  // 20 ns clock
  initial begin
    clk_main_a0 = 1'b0;
    forever #(clk_period / 2) clk_main_a0 = ~clk_main_a0;
  end

  // Hang guard sized from the table length
  initial begin
    #(watchdog_ns);
    $display("Watchdog expired, the run hung waiting for a handshake");
    $display("SIMULATION FAILED");
    $fatal(1, "Timeout");
  end

  //------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic write_access(input logic [31:0] addr, input logic [31:0] data);
    int stall;
    stall = $random(seed) & 3;
    awvalid = 1'b1;
    awaddr  = addr;
    while (!awready) @(negedge clk_main_a0);
    // Address edge passed
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    // wready follows wvalid combinationally, looked at on the rising edge
    @(posedge clk_main_a0);
    while (!wready) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    wvalid = 1'b0;
    // Response one cycle after the data edge
    check_value("bvalid", 32'd1, 32'(bvalid));
    repeat (stall) begin
      @(negedge clk_main_a0);
      check_value("bvalid", 32'd1, 32'(bvalid));
      check_value("awready", 32'd0, 32'(awready));
    end
    bready = 1'b1;
    @(negedge clk_main_a0);
    bready = 1'b0;
    check_value("bvalid", 32'd0, 32'(bvalid));
  endtask

  task automatic read_access(input logic [31:0] addr, input logic [31:0] expected);
    int stall;
    stall = $random(seed) & 3;
    arvalid = 1'b1;
    araddr  = addr;
    while (!arready) @(negedge clk_main_a0);
    // Address edge passed, response not yet out
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    check_value("rvalid", 32'd0, 32'(rvalid));
    // Second edge raises rvalid
    @(negedge clk_main_a0);
    check_value("rvalid", 32'd1, 32'(rvalid));
    check_value("rdata", expected, rdata);
    repeat (stall) begin
      @(negedge clk_main_a0);
      check_value("rvalid", 32'd1, 32'(rvalid));
      check_value("rdata", expected, rdata);
      check_value("arready", 32'd0, 32'(arready));
    end
    rready = 1'b1;
    @(negedge clk_main_a0);
    rready = 1'b0;
    check_value("rvalid", 32'd0, 32'(rvalid));
  endtask

  //------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------
  initial begin
    rst_main_n_sync = 1'b0;
    awvalid    = 1'b0;
    awaddr     = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    araddr     = '0;
    rready     = 1'b0;
    vdip       = '0;
    last_hello = '0;
    repeat (3) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;

    // Idle state out of reset
    check_value("led", 32'd0, 32'(led));
    check_value("bvalid", 32'd0, 32'(bvalid));
    check_value("rvalid", 32'd0, 32'(rvalid));
    check_value("awready", 32'd1, 32'(awready));
    check_value("arready", 32'd1, 32'(arready));
    check_value("wready", 32'd0, 32'(wready));

    for (int i = 0; i < num_rows; i++) begin
      vdip = accesses[i].vdip;
      if (accesses[i].op == op_wr) begin
        write_access(accesses[i].addr, accesses[i].wdata);
        if (accesses[i].addr == hello_addr) begin
          last_hello = accesses[i].wdata;
        end
      end else begin
        read_access(accesses[i].addr, accesses[i].exp_rdata);
      end
      // LEDs show the hello low half where the switch is on
      repeat (2) @(negedge clk_main_a0);
      check_value("led", 32'(last_hello[15:0] & vdip), 32'(led));
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
